// File: eeprom_pkg.sv
package eeprom_pkg;

    localparam int eeprom_addr_w = 11;
    localparam int num_clients = 2;
    localparam int client_idx_w = (num_clients > 1) ? $clog2(num_clients) : 1;

    // upper nibble of every control byte
    localparam logic [3:0] dev_code = 4'b1010;

    // bit positions of the one-hot main FSM in the serial master
    localparam int st_idle = 0;
    localparam int st_start = 1;     // start condition
    localparam int st_ctrl_wr = 2;
    localparam int st_addr_wr = 3;
    localparam int st_data_wr = 4;
    localparam int st_rstart = 5;    // repeated start
    localparam int st_ctrl_rd = 6;
    localparam int st_data_rd = 7;
    localparam int st_stop = 8;
    localparam int st_done = 9;
    localparam int num_states = 10;

    // one client operation, single byte
    typedef struct packed {
        logic rnw;
        logic [eeprom_addr_w-1:0] addr;
        logic [7:0] wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic nack;     // some acknowledge was missing
    } eeprom_rsp_t;

    // first byte after a start condition
    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] block;   // address bits 10..8
        logic rnw;
    } eeprom_ctrl_t;

    typedef union packed {
        logic [7:0] raw;         // data or low address byte
        eeprom_ctrl_t ctrl;
    } eeprom_byte_u;

endpackage

// File: eeprom_bus_arbiter.sv
`timescale 1ns/1ns
module eeprom_bus_arbiter (
    input  logic CLK,
    input  logic RESET,
    input  logic [eeprom_pkg::num_clients-1:0] client_wr,
    input  logic [eeprom_pkg::num_clients-1:0] client_rd,
    input  logic [eeprom_pkg::num_clients-1:0][eeprom_pkg::eeprom_addr_w-1:0] client_addr,
    input  logic [eeprom_pkg::num_clients-1:0][7:0] client_wdata,
    output logic [eeprom_pkg::num_clients-1:0] client_busy,
    output logic [eeprom_pkg::num_clients-1:0] client_done,
    output eeprom_pkg::eeprom_rsp_t [eeprom_pkg::num_clients-1:0] client_rsp,
    output logic master_start,
    output eeprom_pkg::eeprom_req_t master_req,
    input  logic master_done,
    input  eeprom_pkg::eeprom_rsp_t master_rsp
);
    import eeprom_pkg::*;

    eeprom_req_t [num_clients-1:0] pend_req;   // latched strobes
    logic [num_clients-1:0] pend;              // accepted, not yet granted
    logic [num_clients-1:0] acc;
    logic active;                              // master working for owner
    logic [client_idx_w-1:0] owner;
    logic grant_vld;
    logic grant_fire;
    logic [client_idx_w-1:0] grant_idx;
    int rr_idx;

    assign acc = (client_wr | client_rd) & ~client_busy;
    assign grant_fire = !active && grant_vld;

    // round robin, last owner has lowest priority
    always_comb
    begin
        grant_vld = 1'b0;
        grant_idx = owner;
        rr_idx = 0;
        // walk backwards so the client just after the owner is kept
        for (int k = num_clients; k >= 1; k--)
        begin
            rr_idx = (int'(owner) + k) % num_clients;
            if (pend[rr_idx])
            begin
                grant_vld = 1'b1;
                grant_idx = client_idx_w'(rr_idx);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            client_busy <= '0;
            client_done <= '0;
            pend <= '0;
            active <= 1'b0;
            owner <= client_idx_w'(num_clients - 1);   // client 0 goes first
            master_start <= 1'b0;
        end
        else
        begin
            master_start <= 1'b0;
            client_done <= '0;
            for (int i = 0; i < num_clients; i++)
            begin
                if (acc[i])
                begin
                    client_busy[i] <= 1'b1;
                    pend[i] <= 1'b1;
                end
            end
            if (master_done && active)
            begin
                active <= 1'b0;
                client_busy[owner] <= 1'b0;
                client_done[owner] <= 1'b1;
            end
            else if (grant_fire)
            begin
                active <= 1'b1;
                owner <= grant_idx;
                pend[grant_idx] <= 1'b0;
                master_start <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < num_clients; i++)
        begin
            if (acc[i])   // wr wins over rd
                pend_req[i] <= '{rnw: ~client_wr[i], addr: client_addr[i],
                                 wdata: client_wdata[i]};
        end
        if (grant_fire)
            master_req <= pend_req[grant_idx];   // held until the next grant
        if (master_done && active)
            client_rsp[owner] <= master_rsp;
    end

endmodule

// File: eeprom_serial_master.sv
`timescale 1ns/1ns
module eeprom_serial_master (
    input  logic CLK,
    input  logic RESET,
    input  logic start,
    input  eeprom_pkg::eeprom_req_t req,
    output logic done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic scl,
    output logic sda_drive_low,
    input  logic sda_in
);
    import eeprom_pkg::*;

    logic [num_states-1:0] state;
    logic [1:0] qtr;          // quarter of the current bit slot
    logic [3:0] bit_cnt;      // 0..7 data bits, 8 is the ack bit
    eeprom_byte_u sh;         // shift register
    eeprom_byte_u ctrl_byte;
    logic [7:0] rdata_q;
    logic nack_q;
    logic in_start;
    logic in_stop;
    logic in_wbyte;
    logic in_rbyte;
    logic seq_run;
    logic slot_end;
    logic ack_slot;

    function automatic logic [num_states-1:0] hot(input int idx);
        hot = '0;
        hot[idx] = 1'b1;
    endfunction

    // sub-sequence selects
    assign in_start = state[st_start] | state[st_rstart];
    assign in_stop = state[st_stop];
    assign in_wbyte = state[st_ctrl_wr] | state[st_addr_wr] | state[st_data_wr]
                    | state[st_ctrl_rd];
    assign in_rbyte = state[st_data_rd];
    assign seq_run = in_start | in_stop | in_wbyte | in_rbyte;
    assign slot_end = seq_run && (qtr == 2'd3);
    assign ack_slot = (bit_cnt == 4'd8);

    // rnw only set for the control byte after the repeated start
    always_comb
    begin
        ctrl_byte.ctrl = '{dev: dev_code,
                           block: req.addr[eeprom_addr_w-1:8],
                           rnw: state[st_rstart]};
    end

    assign done = state[st_done];
    assign rsp = '{rdata: rdata_q, nack: nack_q};

    // main FSM
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= hot(st_idle);
            qtr <= '0;
            bit_cnt <= '0;
            nack_q <= 1'b0;
        end
        else
        begin
            if (seq_run)
                qtr <= qtr + 2'd1;
            if (slot_end && (in_wbyte || in_rbyte))
                bit_cnt <= ack_slot ? 4'd0 : bit_cnt + 4'd1;

            // sda still high at the ack sample point means no slave answered
            if (slot_end && in_wbyte && ack_slot && sda_in)
                nack_q <= 1'b1;

            unique case (1'b1)
                state[st_idle]:
                    if (start)
                    begin
                        state <= hot(st_start);
                        nack_q <= 1'b0;
                    end
                state[st_start]:
                    if (slot_end)
                        state <= hot(st_ctrl_wr);
                state[st_ctrl_wr]:
                    if (slot_end && ack_slot)
                        state <= hot(st_addr_wr);
                state[st_addr_wr]:
                    if (slot_end && ack_slot)
                        state <= req.rnw ? hot(st_rstart) : hot(st_data_wr);
                state[st_data_wr]:
                    if (slot_end && ack_slot)
                        state <= hot(st_stop);
                state[st_rstart]:
                    if (slot_end)
                        state <= hot(st_ctrl_rd);
                state[st_ctrl_rd]:
                    if (slot_end && ack_slot)
                        state <= hot(st_data_rd);
                state[st_data_rd]:
                    if (slot_end && ack_slot)
                        state <= hot(st_stop);
                state[st_stop]:
                    if (slot_end)
                        state <= hot(st_done);
                state[st_done]:
                    state <= hot(st_idle);
                default:
                    state <= hot(st_idle);
            endcase
        end
    end

    // bus pins, scl low in quarters 0-1 and high in 2-3
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else if (seq_run)
        begin
            case (qtr)
                2'd0:
                    scl <= 1'b0;
                2'd1:   // middle of scl low
                begin
                    if (in_start)
                        sda_drive_low <= 1'b0;
                    else if (in_stop)
                        sda_drive_low <= 1'b1;
                    else if (in_wbyte && !ack_slot)
                        sda_drive_low <= ~sh.raw[7];
                    else
                        sda_drive_low <= 1'b0;   // ack, read bits, final nack
                end
                2'd2:
                    scl <= 1'b1;
                2'd3:   // middle of scl high
                begin
                    if (in_start)
                        sda_drive_low <= 1'b1;   // start condition
                    else if (in_stop)
                        sda_drive_low <= 1'b0;   // stop condition
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state[st_idle] && start)
            rdata_q <= '0;
        if (slot_end)
        begin
            if (in_start)
                sh <= ctrl_byte;
            else if ((in_wbyte || in_rbyte) && !ack_slot)
                sh.raw <= {sh.raw[6:0], sda_in};
            else if (state[st_ctrl_wr])
                sh.raw <= req.addr[7:0];
            else if (state[st_addr_wr])
                sh.raw <= req.wdata;   // unused on reads
            if (in_rbyte && ack_slot)
                rdata_q <= sh.raw;
        end
    end

endmodule

// File: eeprom_subsys_top.sv
`timescale 1ns/1ns
module eeprom_subsys_top (
    input  logic CLK,
    input  logic RESET,
    input  logic [eeprom_pkg::num_clients-1:0] client_wr,
    input  logic [eeprom_pkg::num_clients-1:0] client_rd,
    input  logic [eeprom_pkg::num_clients-1:0][eeprom_pkg::eeprom_addr_w-1:0] client_addr,
    input  logic [eeprom_pkg::num_clients-1:0][7:0] client_wdata,
    output logic [eeprom_pkg::num_clients-1:0] client_busy,
    output logic [eeprom_pkg::num_clients-1:0] client_done,
    output eeprom_pkg::eeprom_rsp_t [eeprom_pkg::num_clients-1:0] client_rsp,
    output logic scl,
    output logic sda_drive_low,   // open drain, high pulls sda low
    input  logic sda_in
);
    import eeprom_pkg::*;

    logic master_start;
    eeprom_req_t master_req;
    logic master_done;
    eeprom_rsp_t master_rsp;

    eeprom_bus_arbiter i_arbiter (
        .CLK          (CLK),
        .RESET        (RESET),
        .client_wr    (client_wr),
        .client_rd    (client_rd),
        .client_addr  (client_addr),
        .client_wdata (client_wdata),
        .client_busy  (client_busy),
        .client_done  (client_done),
        .client_rsp   (client_rsp),
        .master_start (master_start),
        .master_req   (master_req),
        .master_done  (master_done),
        .master_rsp   (master_rsp)
    );

    // single master on the two-wire bus
    eeprom_serial_master i_master (
        .CLK           (CLK),
        .RESET         (RESET),
        .start         (master_start),
        .req           (master_req),
        .done          (master_done),
        .rsp           (master_rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// File: eeprom_mem_model.sv
`timescale 1ns/1ns
module eeprom_mem_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_mode,
    output logic sda_drive_low
);
    import eeprom_pkg::*;

    localparam int mem_size = 1 << eeprom_addr_w;

    logic [7:0] mem [0:mem_size-1];
    logic scl_q;
    logic sda_q;
    logic active;       // between start and stop
    logic selected;     // control byte matched
    logic tx;           // slave sends read data
    logic [3:0] bit_cnt;
    logic [1:0] byte_idx;
    eeprom_byte_u sh;
    logic [2:0] block;
    logic [eeprom_addr_w-1:0] ptr;
    logic [7:0] tx_byte;

    // fill depends on every address bit
    initial
    begin
        for (int a = 0; a < mem_size; a++)
            mem[a] = 8'(a ^ (a >> 3) ^ 8'h5a);
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            active <= 1'b0;
            selected <= 1'b0;
            tx <= 1'b0;
            bit_cnt <= '0;
            byte_idx <= '0;
            sda_drive_low <= 1'b0;
        end
        else if (scl_q && scl && sda_q && !sda)   // start or repeated start
        begin
            active <= 1'b1;
            selected <= 1'b0;
            tx <= 1'b0;
            bit_cnt <= '0;
            byte_idx <= '0;
        end
        else if (scl_q && scl && !sda_q && sda)   // stop
        begin
            active <= 1'b0;
            tx <= 1'b0;
            sda_drive_low <= 1'b0;
        end
        else if (active && !scl_q && scl)
        begin
            if (bit_cnt == 4'd8)
            begin
                bit_cnt <= '0;
                if (tx && sda)
                    tx <= 1'b0;   // master nack ends the read
            end
            else
            begin
                sh.raw <= {sh.raw[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
        else if (active && scl_q && !scl)
        begin
            sda_drive_low <= 1'b0;
            if (bit_cnt == 4'd8 && !tx)
            begin
                // a full byte came in, answer in the ack slot
                case (byte_idx)
                    2'd0:
                        if (sh.ctrl.dev == dev_code && !nack_mode)
                        begin
                            selected <= 1'b1;
                            sda_drive_low <= 1'b1;
                            block <= sh.ctrl.block;
                            if (sh.ctrl.rnw)
                            begin
                                tx <= 1'b1;
                                tx_byte <= mem[{sh.ctrl.block, ptr[7:0]}];
                            end
                        end
                    2'd1:
                        if (selected)
                        begin
                            ptr <= {block, sh.raw};
                            sda_drive_low <= 1'b1;
                        end
                    default:
                        if (selected)
                        begin
                            mem[ptr] <= sh.raw;
                            sda_drive_low <= 1'b1;
                        end
                endcase
                if (byte_idx != 2'd3)
                    byte_idx <= byte_idx + 2'd1;
            end
            else if (tx && bit_cnt < 4'd8)
                sda_drive_low <= ~tx_byte[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

// File: eeprom_checker.sv
`timescale 1ns/1ns
module eeprom_checker (
    input  logic CLK,
    input  logic RESET,
    input  logic nack_mode,
    input  logic [eeprom_pkg::num_clients-1:0] client_wr,
    input  logic [eeprom_pkg::num_clients-1:0] client_rd,
    input  logic [eeprom_pkg::num_clients-1:0][eeprom_pkg::eeprom_addr_w-1:0] client_addr,
    input  logic [eeprom_pkg::num_clients-1:0][7:0] client_wdata,
    input  logic [eeprom_pkg::num_clients-1:0] client_busy,
    input  logic [eeprom_pkg::num_clients-1:0] client_done,
    input  eeprom_pkg::eeprom_rsp_t [eeprom_pkg::num_clients-1:0] client_rsp,
    input  logic scl,
    input  logic sda_drive_low,
    output int err_count
);
    import eeprom_pkg::*;

    localparam int mem_size = 1 << eeprom_addr_w;

    logic [7:0] shadow [0:mem_size-1];
    eeprom_req_t [num_clients-1:0] exp_req;
    logic [num_clients-1:0] outst;
    logic [num_clients-1:0] exp_nack;
    logic [num_clients-1:0] acc;
    logic pair_same;      // both accepted in one cycle, order still open
    int last_done;
    logic reset_q;

    initial
    begin
        err_count = 0;
        for (int a = 0; a < mem_size; a++)
            shadow[a] = 8'(a ^ (a >> 3) ^ 8'h5a);
    end

    task automatic report(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic check_done(input int c);
        eeprom_rsp_t rsp;
        rsp = client_rsp[c];
        if (!outst[c])
            report($sformatf("client %0d done without a request", c));
        else if (!exp_req[c].rnw)
        begin
            if (rsp.nack != exp_nack[c])
                report($sformatf("client %0d write nack %0b, expected %0b", c, rsp.nack,
                                 exp_nack[c]));
            if (!exp_nack[c])
                shadow[exp_req[c].addr] = exp_req[c].wdata;
        end
        else
        begin
            if (rsp.nack)
                report($sformatf("client %0d read got nack", c));
            if (rsp.rdata != shadow[exp_req[c].addr])
                report($sformatf("client %0d read %h at %h, expected %h", c, rsp.rdata,
                                 exp_req[c].addr, shadow[exp_req[c].addr]));
        end
        if (pair_same)
        begin
            if (c != (last_done + 1) % num_clients)
                report($sformatf("client %0d finished first, out of round-robin order", c));
            pair_same = 1'b0;
        end
        last_done = c;
        outst[c] = 1'b0;
    endtask

    always @(posedge CLK)
    begin
        reset_q <= RESET;
        if (RESET)
        begin
            outst = '0;
            pair_same = 1'b0;
            last_done = num_clients - 1;
        end
        else
        begin
            if (reset_q && (client_busy != '0 || client_done != '0 || !scl || sda_drive_low))
                report("outputs not idle after reset");
            for (int i = 0; i < num_clients; i++)
                if (client_done[i])
                    check_done(i);
            // busy from the cycle after acceptance until done
            if (client_busy != outst)
                report($sformatf("busy %b, expected %b", client_busy, outst));
            acc = (client_wr | client_rd) & ~outst;   // strobes only count when idle
            for (int i = 0; i < num_clients; i++)
            begin
                if (acc[i])
                begin
                    exp_req[i] = '{rnw: ~client_wr[i], addr: client_addr[i],
                                   wdata: client_wdata[i]};
                    exp_nack[i] = nack_mode;
                    outst[i] = 1'b1;
                end
            end
            if (&acc)
                pair_same = 1'b1;
        end
    end

endmodule

// File: eeprom_tb_sva.sv
`timescale 1ns/1ns
module eeprom_tb_sva (
    input logic CLK,
    input logic RESET,
    input logic done,
    input logic scl,
    input logic sda_drive_low,
    input logic idle,
    input logic in_start,
    input logic in_stop
);

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done held for more than one cycle");

    // sda moves with scl high only for start and stop conditions
    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_drive_low) && scl) |-> $past(in_start || in_stop))
        else $error("sda changed while scl high outside start or stop");

    a_idle_scl: assert property (@(posedge CLK) disable iff (RESET) idle |-> scl)
        else $error("scl low while master idle");

endmodule

bind eeprom_serial_master eeprom_tb_sva i_sva (
    .CLK           (CLK),
    .RESET         (RESET),
    .done          (done),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .idle          (state[eeprom_pkg::st_idle]),
    .in_start      (in_start),
    .in_stop       (in_stop)
);

// File: eeprom_tb.sv
`timescale 1ns/1ns
module eeprom_tb;
    import eeprom_pkg::*;

    typedef struct packed {
        logic [client_idx_w-1:0] client;
        logic rnw;
        logic [eeprom_addr_w-1:0] addr;
        logic [7:0] wdata;
        logic same;      // strobe together with the next row
        logic nack;      // model does not acknowledge
    } row_t;

    localparam int num_rows = 14;
    localparam int done_timeout = 2000;

    row_t rows [num_rows];
    int row_cnt;
    integer seed;
    logic CLK;
    logic RESET;
    logic [num_clients-1:0] client_wr;
    logic [num_clients-1:0] client_rd;
    logic [num_clients-1:0][eeprom_addr_w-1:0] client_addr;
    logic [num_clients-1:0][7:0] client_wdata;
    logic [num_clients-1:0] client_busy;
    logic [num_clients-1:0] client_done;
    eeprom_rsp_t [num_clients-1:0] client_rsp;
    logic scl;
    logic sda_drive_low;
    logic model_low;
    logic sda;
    logic nack_mode;
    int tb_errors;
    int chk_errors;

    assign sda = ~(sda_drive_low | model_low);   // wired-AND with pull-up

    eeprom_subsys_top i_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .client_wr     (client_wr),
        .client_rd     (client_rd),
        .client_addr   (client_addr),
        .client_wdata  (client_wdata),
        .client_busy   (client_busy),
        .client_done   (client_done),
        .client_rsp    (client_rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_mem_model i_mem (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .nack_mode     (nack_mode),
        .sda_drive_low (model_low)
    );

    eeprom_checker i_checker (
        .CLK           (CLK),
        .RESET         (RESET),
        .nack_mode     (nack_mode),
        .client_wr     (client_wr),
        .client_rd     (client_rd),
        .client_addr   (client_addr),
        .client_wdata  (client_wdata),
        .client_busy   (client_busy),
        .client_done   (client_done),
        .client_rsp    (client_rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .err_count     (chk_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic add_row(input int c, input logic rnw, input int addr, input logic same,
                           input logic nack);
        row_t r;
        r.client = client_idx_w'(c);
        r.rnw = rnw;
        r.addr = eeprom_addr_w'(addr);
        r.wdata = rnw ? 8'h00 : 8'($random(seed));
        r.same = same;
        r.nack = nack;
        rows[row_cnt] = r;
        row_cnt++;
    endtask

    task automatic apply_strobe(input row_t r);
        client_wr[r.client] <= ~r.rnw;
        client_rd[r.client] <= r.rnw;
        client_addr[r.client] <= r.addr;
        client_wdata[r.client] <= r.wdata;
        nack_mode <= r.nack;
    endtask

    task automatic clear_strobes();
        client_wr <= '0;
        client_rd <= '0;
    endtask

    // second write while busy, must be dropped
    task automatic poke_while_busy(input row_t r);
        @(posedge CLK);
        client_wr[r.client] <= 1'b1;
        client_wdata[r.client] <= ~r.wdata;
        @(posedge CLK);
        clear_strobes();
    endtask

    task automatic wait_done(input logic [num_clients-1:0] mask);
        logic [num_clients-1:0] seen;
        int n;
        seen = '0;
        n = 0;
        while ((seen & mask) != mask && n < done_timeout)
        begin
            @(posedge CLK);
            seen |= client_done;
            n++;
        end
        if ((seen & mask) != mask)
        begin
            $display("timeout: no done from clients %b after %0d cycles", mask, n);
            tb_errors++;
        end
    endtask

    initial
    begin
        int r;
        seed = 32'hedbd_0c0e;
        RESET = 1'b1;
        client_wr = '0;
        client_rd = '0;
        client_addr = '0;
        client_wdata = '0;
        nack_mode = 1'b0;
        tb_errors = 0;
        row_cnt = 0;

        add_row(0, 1'b0, 'h055, 1'b0, 1'b0);   // write then read
        add_row(0, 1'b1, 'h055, 1'b0, 1'b0);
        add_row(0, 1'b0, 'h123, 1'b1, 1'b0);   // both clients together
        add_row(1, 1'b0, 'h3a7, 1'b0, 1'b0);
        add_row(0, 1'b1, 'h123, 1'b1, 1'b0);
        add_row(1, 1'b1, 'h3a7, 1'b0, 1'b0);
        add_row(1, 1'b0, 'h010, 1'b0, 1'b0);   // only block bits differ
        add_row(1, 1'b0, 'h110, 1'b0, 1'b0);
        add_row(0, 1'b0, 'h710, 1'b0, 1'b0);
        add_row(0, 1'b1, 'h010, 1'b0, 1'b0);
        add_row(1, 1'b1, 'h110, 1'b0, 1'b0);
        add_row(0, 1'b1, 'h710, 1'b0, 1'b0);
        add_row(0, 1'b0, 'h055, 1'b0, 1'b1);   // no acknowledge
        add_row(0, 1'b1, 'h055, 1'b0, 1'b0);

        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        repeat (2) @(posedge CLK);

        r = 0;
        while (r < row_cnt)
        begin
            if (rows[r].same && r + 1 < row_cnt)
            begin
                apply_strobe(rows[r]);
                apply_strobe(rows[r + 1]);
                @(posedge CLK);
                clear_strobes();
                wait_done((num_clients'(1) << rows[r].client)
                          | (num_clients'(1) << rows[r + 1].client));
                r += 2;
            end
            else
            begin
                apply_strobe(rows[r]);
                @(posedge CLK);
                clear_strobes();
                if (!rows[r].rnw)
                    poke_while_busy(rows[r]);
                wait_done(num_clients'(1) << rows[r].client);
                r++;
            end
            nack_mode <= 1'b0;
            repeat (2) @(posedge CLK);
        end

        repeat (4) @(posedge CLK);
        $display("checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: build.f
eeprom_pkg.sv
eeprom_bus_arbiter.sv
eeprom_serial_master.sv
eeprom_subsys_top.sv
eeprom_mem_model.sv
eeprom_checker.sv
eeprom_tb_sva.sv
eeprom_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the eeprom testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module eeprom_tb \
    -f build.f -o eeprom_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/eeprom_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
